// ==== Bender.yml ====
package:
  name: instr_fetch_front_end

dependencies: {}

sources:
  # shared types and constants first
  - hdl/irPkg.sv
  # fetch unit, queue control and registers
  - hdl/instrFetch.sv
  - hdl/irControl.sv
  - hdl/ir.sv
  # top level
  - hdl/fetchTop.sv

  # testbench
  - target: simulation
    files:
      - verif/fetchTb.sv

// ==== hdl/fetchTop.sv ====
/*
  Instruction fetch front end.
  Connects the credit-based fetch unit, the queue control and
  the instruction registers. Memory requests leave on reqValid and
  reqAddr, words return on rspValid and rspData, and the decoder
  pops with nextInstr.
*/

`default_nettype none
`timescale 1ns/10ps

module fetchTop import irPkg::*; (
  input  wire logic  phi1,
  input  wire logic  arstN,
  input  wire logic  test,
  input  wire logic  scanIn,
  output logic       scanOut,
  output logic       reqValid,
  output addrT       reqAddr,
  input  wire logic  rspValid,
  input  wire instrT rspData,
  input  wire logic  nextInstr,
  output instrT      irNext,
  output logic       nextValid,
  output instrT      irCurr,
  output logic       currValid
);

  logic enIR1;
  logic enIR2;
  logic enIRcurr;
  logic selIR2;
  logic creditReturn;

  instrFetch i_instrFetch (
    .phi1         (phi1),
    .arstN        (arstN),
    .test         (test),
    .creditReturn (creditReturn),
    .reqValid     (reqValid),
    .reqAddr      (reqAddr)
  );

  irControl i_irControl (
    .phi1         (phi1),
    .arstN        (arstN),
    .test         (test),
    .rspValid     (rspValid),
    .nextInstr    (nextInstr),
    .enIR1        (enIR1),
    .enIR2        (enIR2),
    .enIRcurr     (enIRcurr),
    .selIR2       (selIR2),
    .nextValid    (nextValid),
    .currValid    (currValid),
    .creditReturn (creditReturn)
  );

  // memory words go straight onto the IR1 input
  ir i_ir (
    .phi1     (phi1),
    .arstN    (arstN),
    .test     (test),
    .scanIn   (scanIn),
    .scanOut  (scanOut),
    .dataBus  (rspData),
    .enIR1    (enIR1),
    .enIR2    (enIR2),
    .enIRcurr (enIRcurr),
    .selIR2   (selIR2),
    .irNext   (irNext),
    .irCurr   (irCurr)
  );

endmodule : fetchTop

`default_nettype wire

// ==== hdl/instrFetch.sv ====
/*
  Instruction fetch unit.
  Keeps the program counter and a credit counter. Issues one
  sequential word read per cycle while credits remain, so the
  instruction memory never has to stall a request. Credits come
  back from the queue control when a word moves into IRcurr.
*/

`default_nettype none
`timescale 1ns/10ps

module instrFetch import irPkg::*; (
  input  wire logic phi1,
  input  wire logic arstN,
  input  wire logic test,
  input  wire logic creditReturn,
  output logic      reqValid,
  output addrT      reqAddr
);

  addrT   pc;
  creditT credits;
  creditT creditsNext;

  // a slot is guaranteed for every credit held
  assign reqValid = (credits != '0) && !test;
  assign reqAddr  = pc;

  // one credit spent per request and one back per returned pulse
  always_comb begin
    case ({reqValid, creditReturn})
      2'b10:   creditsNext = credits - 2'd1;
      2'b01:   creditsNext = credits + 2'd1;
      default: creditsNext = credits;
    endcase
  end

  // program counter
  always_ff @(posedge phi1 or negedge arstN) begin
    if (!arstN) begin
      pc <= ResetVector;
    end else if (reqValid) begin
      pc <= pc + addrT'(InstrBytes);
    end
  end

  // credit counter frozen while scanning
  always_ff @(posedge phi1 or negedge arstN) begin
    if (!arstN) begin
      credits <= creditT'(QueueDepth);
    end else if (!test) begin
      credits <= creditsNext;
    end
  end

  // returns from irControl must never push the count past the queue size
  creditBound: assert property (
    @(posedge phi1) disable iff (!arstN)
    credits <= creditT'(QueueDepth)
  ) else $error("credit count above queue depth");

  // a credit can only come back once one has been spent
  returnAfterSpend: assert property (
    @(posedge phi1) disable iff (!arstN)
    (creditReturn && !reqValid) |-> (credits < creditT'(QueueDepth))
  ) else $error("credit returned while all credits held");

endmodule : instrFetch

`default_nettype wire

// ==== hdl/ir.sv ====
/*
  Instruction queue registers.
  IR1 takes words from the memory bus, IR2 holds the older queued
  word and IRcurr the instruction being decoded. The lookahead mux
  picks the oldest queued word. In test mode the three registers
  form one 96-bit scan chain, IR1 first and IRcurr last.
*/

`default_nettype none
`timescale 1ns/10ps

module ir import irPkg::*; (
  input  wire logic  phi1,
  input  wire logic  arstN,
  input  wire logic  test,
  input  wire logic  scanIn,
  output logic       scanOut,
  input  wire instrT dataBus,
  input  wire logic  enIR1,
  input  wire logic  enIR2,
  input  wire logic  enIRcurr,
  input  wire logic  selIR2,
  output instrT      irNext,
  output instrT      irCurr
);

  instrT ir1;
  instrT ir2;

  // oldest queued word for the decoder
  assign irNext  = selIR2 ? ir2 : ir1;
  assign scanOut = irCurr[31];

  // newest word, head of the scan chain
  always_ff @(posedge phi1 or negedge arstN) begin
    if (!arstN) begin
      ir1 <= '0;
    end else if (test) begin
      ir1 <= {ir1[30:0], scanIn};
    end else if (enIR1) begin
      ir1 <= dataBus;
    end
  end

  // older word, loads from IR1
  always_ff @(posedge phi1 or negedge arstN) begin
    if (!arstN) begin
      ir2 <= '0;
    end else if (test) begin
      ir2 <= {ir2[30:0], ir1[31]};
    end else if (enIR2) begin
      ir2 <= ir1;
    end
  end

  // current instruction, loads through the lookahead mux
  always_ff @(posedge phi1 or negedge arstN) begin
    if (!arstN) begin
      irCurr <= '0;
    end else if (test) begin
      irCurr <= {irCurr[30:0], ir2[31]};
    end else if (enIRcurr) begin
      irCurr <= irNext;
    end
  end

  // shifting IR1 into IR2 while IR2 feeds IRcurr needs the mux on IR2
  shiftUsesIR2: assert property (
    @(posedge phi1) disable iff (!arstN)
    (!test && enIR2 && enIRcurr) |-> selIR2
  ) else $error("IR2 overwritten before it reached IRcurr");

endmodule : ir

`default_nettype wire

// ==== hdl/irControl.sv ====
/*
  Instruction queue control.
  Tracks how many words sit in IR1/IR2 and turns memory responses
  (push) and decoder requests (pop) into the register load enables
  and the lookahead select. A word moving into IRcurr gives a credit
  back to the fetch unit one edge later. All state holds in test mode.
*/

`default_nettype none
`timescale 1ns/10ps

module irControl import irPkg::*; (
  input  wire logic phi1,
  input  wire logic arstN,
  input  wire logic test,
  input  wire logic rspValid,
  input  wire logic nextInstr,
  output logic      enIR1,
  output logic      enIR2,
  output logic      enIRcurr,
  output logic      selIR2,
  output logic      nextValid,
  output logic      currValid,
  output logic      creditReturn
);

  qStateT state;
  qStateT stateNext;
  logic   push;
  logic   pop;
  creditT fill;

  assign push = rspValid && !test;
  // pop on an empty queue is dropped
  assign pop  = nextInstr && !test && (state != qEmpty);

  assign nextValid = (state != qEmpty);
  // older word lives in IR2 only when both slots are full
  assign selIR2    = (state == qTwo);

  // occupancy as a count, matches the enum encoding
  assign fill = creditT'(state);

  always_comb begin
    stateNext = state;
    enIR1     = 1'b0;
    enIR2     = 1'b0;
    enIRcurr  = 1'b0;
    case (state)
      qEmpty: begin
        if (push) begin
          enIR1     = 1'b1;
          stateNext = qOne;
        end
      end
      qOne: begin
        if (pop) begin
          // IRcurr takes IR1, IR1 refills if a word arrives
          enIRcurr = 1'b1;
          enIR1    = push;
          if (!push) begin
            stateNext = qEmpty;
          end
        end else if (push) begin
          // IR1 shifts down into IR2
          enIR1     = 1'b1;
          enIR2     = 1'b1;
          stateNext = qTwo;
        end
      end
      qTwo: begin
        if (pop) begin
          enIRcurr = 1'b1;
          enIR2    = push;
          enIR1    = push;
          if (!push) begin
            stateNext = qOne;
          end
        end
      end
      default: stateNext = qEmpty;
    endcase
  end

  always_ff @(posedge phi1 or negedge arstN) begin
    if (!arstN) begin
      state        <= qEmpty;
      currValid    <= 1'b0;
      creditReturn <= 1'b0;
    end else if (!test) begin
      state        <= stateNext;
      creditReturn <= pop;
      if (pop) begin
        currValid <= 1'b1;
      end
    end
  end

  // fetch credits must keep the memory from overrunning a full queue
  noOverflow: assert property (
    @(posedge phi1) disable iff (!arstN)
    !(push && !pop && (fill == creditT'(QueueDepth)))
  ) else $error("response arrived with the queue full");

endmodule : irControl

`default_nettype wire

// ==== hdl/irPkg.sv ====
/*
  Instruction fetch shared definitions.
  Word and address types, the credit count type, the queue
  occupancy encoding and the fetch constants used by the
  fetch unit, the queue control and the instruction registers.
*/

`default_nettype none

package irPkg;

  // datapath widths
  localparam int InstrWidth = 32;
  localparam int AddrWidth  = 32;

  // one instruction word as returned by memory
  typedef logic [InstrWidth-1:0] instrT;

  // byte address into instruction memory
  typedef logic [AddrWidth-1:0] addrT;

  // credits held by the fetch unit, 0 to QueueDepth
  typedef logic [1:0] creditT;

  // number of words the queue can hold (IR1 and IR2)
  localparam int QueueDepth = 2;

  // first fetch address after reset
  localparam addrT ResetVector = 32'h0000_1000;

  // address step between sequential instructions
  localparam int InstrBytes = 4;

  // IR1, IR2 and IRcurr, 32 bits each
  localparam int ScanLength = 3 * InstrWidth;

  // queue occupancy
  // qOne holds its word in IR1, qTwo has the older word in IR2
  typedef enum logic [1:0] {
    qEmpty = 2'd0,
    qOne   = 2'd1,
    qTwo   = 2'd2
  } qStateT;

endpackage : irPkg

`default_nettype wire

// ==== project.f ====
hdl/irPkg.sv
hdl/instrFetch.sv
hdl/irControl.sv
hdl/ir.sv
hdl/fetchTop.sv
verif/fetchTb.sv

// ==== verif/fetchTb.sv ====
/*
  Instruction fetch front end testbench.
  Drives fetchTop with a random-latency memory model and a random
  decoder, keeps the expected word sequence, checks addresses, flow
  control, queue contents and IRcurr, then shifts a random pattern
  through the 96-bit scan chain.
*/

`default_nettype none
`timescale 1ns/10ps

module fetchTb import irPkg::*; ();

  localparam int NumInstr    = 200;
  localparam int ScanCycles  = 200;
  localparam int ResetCycles = 16;
  localparam int TimeoutCycles = NumInstr * 8 + ScanCycles + ResetCycles;
  localparam instrT DataMask = 32'hA5A5_0000;

  logic  phi1;
  logic  arstN;
  logic  test;
  logic  scanIn;
  logic  scanOut;
  logic  reqValid;
  addrT  reqAddr;
  logic  rspValid;
  instrT rspData;
  logic  nextInstr;
  instrT irNext;
  logic  nextValid;
  instrT irCurr;
  logic  currValid;

  // model state
  integer seed;
  int     cyc;
  int     timeoutCount;
  int     popCount;
  int     lastDue;
  int     stallLeft;
  addrT   expAddr;
  instrT  expCurr;
  instrT  rspWord;
  logic   rspPending;
  logic   popPending;
  addrT   reqQ[$];
  int     dueQ[$];
  instrT  pendQ[$];
  logic [ScanLength-1:0] pattern;

  fetchTop i_dut (
    .phi1      (phi1),
    .arstN     (arstN),
    .test      (test),
    .scanIn    (scanIn),
    .scanOut   (scanOut),
    .reqValid  (reqValid),
    .reqAddr   (reqAddr),
    .rspValid  (rspValid),
    .rspData   (rspData),
    .nextInstr (nextInstr),
    .irNext    (irNext),
    .nextValid (nextValid),
    .irCurr    (irCurr),
    .currValid (currValid)
  );

  initial begin
    phi1 = 1'b0;
    forever #10 phi1 = ~phi1;
  end

  task automatic reportMismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic checkInstr(input instrT act, input instrT exp, input string what);
    if (act !== exp) begin
      reportMismatch($sformatf("%s is %h, expected %h", what, act, exp));
    end
  endtask

  task automatic checkAddr(input addrT act, input addrT exp, input string what);
    if (act !== exp) begin
      reportMismatch($sformatf("%s is %h, expected %h", what, act, exp));
    end
  endtask

  task automatic checkBit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      reportMismatch($sformatf("%s is %b, expected %b", what, act, exp));
    end
  endtask

  // retire the last edge's effects then check and drive
  task automatic stepCycle(input logic decoderOn);
    int due;
    cyc++;
    // pop and push taken at the rising edge just passed
    if (popPending) begin
      expCurr = pendQ.pop_front();
      popCount++;
    end
    if (rspPending) begin
      pendQ.push_back(rspWord);
      void'(reqQ.pop_front());
      void'(dueQ.pop_front());
    end
    checkInstr(irCurr, expCurr, "irCurr");
    checkBit(currValid, popCount != 0, "currValid");
    checkBit(nextValid, pendQ.size() != 0, "nextValid");
    if (pendQ.size() != 0) begin
      checkInstr(irNext, pendQ[0], "irNext");
    end
    // request taken at the coming rising edge
    if (reqValid) begin
      checkAddr(reqAddr, expAddr, "reqAddr");
      due = cyc + 1 + ($unsigned($random(seed)) % 6);
      // returns stay in order and at most one per cycle
      if (due <= lastDue) begin
        due = lastDue + 1;
      end
      lastDue = due;
      reqQ.push_back(reqAddr);
      dueQ.push_back(due);
      expAddr = expAddr + addrT'(InstrBytes);
    end
    if (reqQ.size() + pendQ.size() > QueueDepth) begin
      reportMismatch($sformatf("%0d words in flight or queued, only %0d slots",
                               reqQ.size() + pendQ.size(), QueueDepth));
    end
    // memory return
    rspPending = (reqQ.size() != 0) && (dueQ[0] <= cyc);
    rspValid   = rspPending;
    if (rspPending) begin
      rspData = reqQ[0] ^ DataMask;
    end else begin
      rspData = instrT'($random(seed));
    end
    rspWord = rspData;
    // decoder requests about 40% of cycles with occasional stalls
    if (!decoderOn) begin
      nextInstr = 1'b0;
    end else if (stallLeft > 0) begin
      nextInstr = 1'b0;
      stallLeft--;
    end else if ($unsigned($random(seed)) % 32 == 0) begin
      nextInstr = 1'b0;
      stallLeft = 4 + ($unsigned($random(seed)) % 12);
    end else begin
      nextInstr = ($unsigned($random(seed)) % 10) < 4;
    end
    popPending = nextInstr && nextValid;
  endtask

  // run limit
  initial begin
    timeoutCount = 0;
    while (timeoutCount < TimeoutCycles) begin
      @(posedge phi1);
      timeoutCount++;
    end
    $display("Simulation timed out after %0d cycles without finishing", timeoutCount);
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    seed       = 32'h554;
    arstN      = 1'b0;
    test       = 1'b0;
    scanIn     = 1'b0;
    rspValid   = 1'b0;
    rspData    = '0;
    nextInstr  = 1'b0;
    cyc        = 0;
    popCount   = 0;
    lastDue    = 0;
    stallLeft  = 0;
    expAddr    = ResetVector;
    expCurr    = '0;
    rspWord    = '0;
    rspPending = 1'b0;
    popPending = 1'b0;
    repeat (ResetCycles) @(posedge phi1);
    @(negedge phi1);
    arstN = 1'b1;
    checkBit(nextValid, 1'b0, "nextValid after reset");
    checkBit(currValid, 1'b0, "currValid after reset");
    // first request must carry ResetVector
    stepCycle(1'b1);
    while (popCount < NumInstr) begin
      @(negedge phi1);
      stepCycle(1'b1);
    end
    // enter test mode with a credit in hand so only test holds requests back
    do begin
      @(negedge phi1);
      stepCycle(1'b1);
    end while (!reqValid);
    test      = 1'b1;
    rspValid  = 1'b0;
    nextInstr = 1'b0;
    pattern = {$random(seed), $random(seed), $random(seed)};
    for (int i = 0; i < 2 * ScanLength; i++) begin
      @(negedge phi1);
      if (i >= ScanLength) begin
        checkBit(scanOut, pattern[i - ScanLength], $sformatf("scanOut bit %0d", i - ScanLength));
      end
      checkBit(reqValid, 1'b0, "reqValid in test mode");
      scanIn = (i < ScanLength) ? pattern[i] : 1'b0;
    end
    $display("Test OK");
    $finish;
  end

endmodule : fetchTb

`default_nettype wire
